//--- hw/g729Pkg.sv
`default_nettype none

package g729Pkg;

	////////////////////////////////////////
	// Operator word types
	////////////////////////////////////////

	// Q15 operator word
	typedef logic signed [15:0] word16;

	// Q31 long word
	typedef logic signed [31:0] word32;

	// Scratch memory address, 2048 entries
	typedef logic [10:0] memAddr;

	////////////////////////////////////////
	// Operand and result bundles
	////////////////////////////////////////

	// L_mac / L_msu operands, c is the accumulator
	typedef struct packed {
		word16 a;
		word16 b;
		word32 c;
	} macReq;

	typedef struct packed {
		word16 a;
		word16 b;
	} pairReq16;

	typedef struct packed {
		word32 a;
		word32 b;
	} pairReq32;

	// Value and signed shift count for L_shl / L_shr
	typedef struct packed {
		word32 var1;
		word16 numShift;
	} longShiftReq;

	typedef struct packed {
		logic overflow;
		word32 value;
	} longResult;

	// One write port and one read port
	typedef struct packed {
		memAddr waddr;
		word32 wdata;
		logic we;
		memAddr raddr;
	} memPort;

	// Saturation limits
	localparam word16 MaxWord16 = 16'sh7fff;
	localparam word16 MinWord16 = 16'sh8000;
	localparam word32 MaxWord32 = 32'sh7fff_ffff;
	localparam word32 MinWord32 = 32'sh8000_0000;

	localparam int MemDepth = 2048;

endpackage

`default_nettype wire

//--- hw/mulAccUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mulAccUnit (
	input  wire g729Pkg::pairReq16 multReq,
	input  wire g729Pkg::macReq    macReqIn,
	input  wire g729Pkg::macReq    msuReqIn,
	output g729Pkg::longResult     lMultOut,
	output g729Pkg::longResult     macOut,
	output g729Pkg::longResult     msuOut,
	output g729Pkg::word16         multOut
);
	import g729Pkg::*;

	////////////////////////////////////////
	// Shared arithmetic
	////////////////////////////////////////

	// Doubling multiply, only -1 * -1 can overflow
	function automatic longResult multSat(input word16 a, input word16 b);
		word32 prod;
		prod = a * b;
		if (a == MinWord16 && b == MinWord16)
			multSat = '{overflow: 1'b1, value: MaxWord32};
		else
			multSat = '{overflow: 1'b0, value: prod <<< 1};
	endfunction

	// 32-bit sum or difference clamped to the long word range
	function automatic longResult addSat32(input word32 x, input word32 y,
			input logic subtract);
		logic signed [32:0] wide;
		if (subtract)
			wide = x - y;
		else
			wide = x + y;
		if (wide > MaxWord32)
			addSat32 = '{overflow: 1'b1, value: MaxWord32};
		else if (wide < MinWord32)
			addSat32 = '{overflow: 1'b1, value: MinWord32};
		else
			addSat32 = '{overflow: 1'b0, value: wide[31:0]};
	endfunction

	////////////////////////////////////////
	// Operators
	////////////////////////////////////////

	longResult lMult;
	longResult macProd;
	longResult macSum;
	longResult msuProd;
	longResult msuSum;

	assign lMult = multSat(multReq.a, multReq.b);

	// mult is the high half of L_mult, saturated case lands on MaxWord16
	assign multOut = lMult.value[31:16];
	assign lMultOut = lMult;

	// L_mac: c + L_mult(a,b)
	assign macProd = multSat(macReqIn.a, macReqIn.b);
	assign macSum = addSat32(macReqIn.c, macProd.value, 1'b0);

	// L_msu: c - L_mult(a,b)
	assign msuProd = multSat(msuReqIn.a, msuReqIn.b);
	assign msuSum = addSat32(msuReqIn.c, msuProd.value, 1'b1);

	// Overflow from either step is reported
	assign macOut = '{overflow: macProd.overflow | macSum.overflow, value: macSum.value};
	assign msuOut = '{overflow: msuProd.overflow | msuSum.overflow, value: msuSum.value};

endmodule

`default_nettype wire

//--- hw/addShiftUnit.sv
`timescale 1ns/1ps
`default_nettype none

module addShiftUnit (
	input  wire g729Pkg::pairReq16    addReq,
	input  wire g729Pkg::pairReq16    subReq,
	input  wire g729Pkg::pairReq16    shrReq,
	input  wire g729Pkg::pairReq32    lAddReq,
	input  wire g729Pkg::pairReq32    lSubReq,
	input  wire g729Pkg::longShiftReq lShrReq,
	output g729Pkg::word16            addOut,
	output g729Pkg::word16            subOut,
	output g729Pkg::word16            shrOut,
	output g729Pkg::word32            lAddOut,
	output g729Pkg::word32            lSubOut,
	output g729Pkg::word32            lShrOut
);
	import g729Pkg::*;

	////////////////////////////////////////
	// Clamps
	////////////////////////////////////////

	function automatic word16 clamp16(input logic signed [31:0] x);
		if (x > MaxWord16)
			clamp16 = MaxWord16;
		else if (x < MinWord16)
			clamp16 = MinWord16;
		else
			clamp16 = x[15:0];
	endfunction

	function automatic word32 clamp32(input logic signed [63:0] x);
		if (x > MaxWord32)
			clamp32 = MaxWord32;
		else if (x < MinWord32)
			clamp32 = MinWord32;
		else
			clamp32 = x[31:0];
	endfunction

	////////////////////////////////////////
	// Right shifts, negative count goes left
	////////////////////////////////////////

	function automatic word16 shr16(input word16 v, input word16 cnt);
		logic signed [16:0] mag;
		logic signed [31:0] wide;
		mag = cnt;
		mag = -mag;
		wide = v;
		if (!cnt[15] && cnt >= 16'sd15)
			shr16 = {16{v[15]}};
		else if (!cnt[15])
			shr16 = v >>> cnt;
		else if (mag >= 17'sd16)
			shr16 = (v == 0) ? 16'sd0 : (v[15] ? MinWord16 : MaxWord16);
		else
			shr16 = clamp16(wide <<< mag[3:0]);
	endfunction

	function automatic word32 shr32(input word32 v, input word16 cnt);
		logic signed [16:0] mag;
		logic signed [63:0] wide;
		mag = cnt;
		mag = -mag;
		wide = v;
		if (!cnt[15] && cnt >= 16'sd31)
			shr32 = {32{v[31]}};
		else if (!cnt[15])
			shr32 = v >>> cnt;
		// anything nonzero pushed 32 places is already out of range
		else if (mag >= 17'sd32)
			shr32 = (v == 0) ? 32'sd0 : (v[31] ? MinWord32 : MaxWord32);
		else
			shr32 = clamp32(wide <<< mag[4:0]);
	endfunction

	logic signed [31:0] addWide;
	logic signed [31:0] subWide;
	logic signed [63:0] lAddWide;
	logic signed [63:0] lSubWide;

	// Widen before the add so the carry is kept
	assign addWide = addReq.a + addReq.b;
	assign subWide = subReq.a - subReq.b;
	assign lAddWide = lAddReq.a + lAddReq.b;
	assign lSubWide = lSubReq.a - lSubReq.b;

	assign addOut = clamp16(addWide);
	assign subOut = clamp16(subWide);
	assign lAddOut = clamp32(lAddWide);
	assign lSubOut = clamp32(lSubWide);

	assign shrOut = shr16(shrReq.a, shrReq.b);
	assign lShrOut = shr32(lShrReq.var1, lShrReq.numShift);

endmodule

`default_nettype wire

//--- hw/longShiftLeft.sv
`timescale 1ns/1ps
`default_nettype none

module longShiftLeft (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       shlReady,
	input  wire g729Pkg::longShiftReq shlReq,
	output logic                      shlDone,
	output g729Pkg::word32            shlOut
);
	import g729Pkg::*;

	typedef enum logic [1:0] {Idle, Shift, Finish} shlState;

	shlState state;
	word32 value;
	word16 count;
	logic signed [16:0] rightMag;
	logic busy;
	logic start;
	logic negShift;
	logic stopShift;
	logic willOverflow;

	assign busy = (state != Idle);
	assign start = shlReady && !busy;

	// Magnitude of a negative count, 17 bits so -32768 fits
	assign rightMag = -{count[15], count};
	assign negShift = count[15];
	assign stopShift = (count == 16'sd0) || (value == 32'sd0);
	// Top two bits differ, next doubling flips the sign
	assign willOverflow = (value[31] != value[30]);

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= Idle;
		else
		begin
			case (state)
				Idle:
					if (start)
						state <= Shift;
				Shift:
					if (negShift || stopShift || willOverflow)
						state <= Finish;
				default:
					state <= Idle;
			endcase
		end
	end

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			value <= shlReq.var1;
			count <= shlReq.numShift;
		end
		else if (state == Shift)
		begin
			if (negShift)
			begin
				if (rightMag >= 17'sd31)
					value <= {32{value[31]}};
				else
					value <= value >>> rightMag[4:0];
			end
			else if (!stopShift && willOverflow)
				value <= value[31] ? MinWord32 : MaxWord32;
			else if (!stopShift)
			begin
				value <= value <<< 1;
				count <= count - 16'sd1;
			end
		end
	end

	assign shlDone = (state == Finish);
	assign shlOut = value;

	// Done is a single pulse per operation
	assert property (@(posedge clk) disable iff (rst) shlDone |=> !shlDone);

	// Result register only moves once a start has been taken
	assert property (@(posedge clk) disable iff (rst)
		(state == Idle && !shlReady && !$isunknown(value)) |=> $stable(value));

endmodule

`default_nettype wire

//--- hw/normalizer.sv
`timescale 1ns/1ps
`default_nettype none

module normalizer (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 normReady,
	input  wire g729Pkg::word16 normIn,
	output logic                normDone,
	output g729Pkg::word16      normOut
);
	import g729Pkg::*;

	typedef enum logic [1:0] {Idle, Count, Finish} normState;

	normState state;
	word16 work;
	word16 shiftCount;
	logic busy;
	logic start;
	logic isZero;
	logic isMinusOne;
	logic topDiffers;
	logic endCount;

	assign busy = (state != Idle);
	assign start = normReady && !busy;

	assign isZero = (work == 16'sd0);
	assign isMinusOne = (work == -16'sd1);
	assign topDiffers = (work[15] != work[14]);
	assign endCount = isZero || isMinusOne || topDiffers;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= Idle;
		else
		begin
			case (state)
				Idle:
					if (start)
						state <= Count;
				Count:
					if (endCount)
						state <= Finish;
				default:
					state <= Idle;
			endcase
		end
	end

	// One redundant sign bit removed per cycle
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			work <= normIn;
			shiftCount <= 16'sd0;
		end
		else if (state == Count)
		begin
			// All ones is defined as 15
			if (isMinusOne)
				shiftCount <= 16'sd15;
			else if (!endCount)
			begin
				work <= work <<< 1;
				shiftCount <= shiftCount + 16'sd1;
			end
		end
	end

	assign normDone = (state == Finish);
	assign normOut = shiftCount;

	assert property (@(posedge clk) disable iff (rst)
		normDone |-> (normOut >= 16'sd0 && normOut <= 16'sd15));

endmodule

`default_nettype wire

//--- hw/scratchMem.sv
`timescale 1ns/1ps
`default_nettype none

module scratchMem (
	input  wire                  clk,
	input  wire                  memSel,
	input  wire g729Pkg::memPort enginePort,
	input  wire g729Pkg::memPort testPort,
	output g729Pkg::word32       memRdata
);
	import g729Pkg::*;

	memPort selPort;
	word32 ram [MemDepth];

	// Test port owns the memory while memSel is high
	assign selPort = memSel ? testPort : enginePort;

	////////////////////////////////////////
	// Simple dual-port RAM
	////////////////////////////////////////

	// Read returns old data on a same-address write
	always_ff @(posedge clk)
	begin
		if (selPort.we)
			ram[selPort.waddr] <= selPort.wdata;
		memRdata <= ram[selPort.raddr];
	end

	// A write needs a known address on whichever port is selected
	assert property (@(posedge clk) selPort.we |-> !$isunknown(selPort.waddr));

endmodule

`default_nettype wire

//--- hw/basicOpPipe.sv
`timescale 1ns/1ps
`default_nettype none

module basicOpPipe (
	input  wire                       clk,
	input  wire                       rst,
	input  wire g729Pkg::pairReq16    multReq,
	input  wire g729Pkg::macReq       macReqIn,
	input  wire g729Pkg::macReq       msuReqIn,
	input  wire g729Pkg::pairReq16    addReq,
	input  wire g729Pkg::pairReq16    subReq,
	input  wire g729Pkg::pairReq16    shrReq,
	input  wire g729Pkg::pairReq32    lAddReq,
	input  wire g729Pkg::pairReq32    lSubReq,
	input  wire g729Pkg::longShiftReq lShrReq,
	input  wire                       shlReady,
	input  wire g729Pkg::longShiftReq shlReq,
	input  wire                       normReady,
	input  wire g729Pkg::word16       normIn,
	input  wire                       memSel,
	input  wire g729Pkg::memPort      enginePort,
	input  wire g729Pkg::memPort      testPort,
	output wire g729Pkg::longResult   lMultOut,
	output wire g729Pkg::longResult   macOut,
	output wire g729Pkg::longResult   msuOut,
	output wire g729Pkg::word16       multOut,
	output wire g729Pkg::word16       addOut,
	output wire g729Pkg::word16       subOut,
	output wire g729Pkg::word16       shrOut,
	output wire g729Pkg::word32       lAddOut,
	output wire g729Pkg::word32       lSubOut,
	output wire g729Pkg::word32       lShrOut,
	output wire                       shlDone,
	output wire g729Pkg::word32       shlOut,
	output wire                       normDone,
	output wire g729Pkg::word16       normOut,
	output wire g729Pkg::word32       memRdata
);

	////////////////////////////////////////
	// Combinational operators
	////////////////////////////////////////

	mulAccUnit uMulAcc (
		.multReq  (multReq),
		.macReqIn (macReqIn),
		.msuReqIn (msuReqIn),
		.lMultOut (lMultOut),
		.macOut   (macOut),
		.msuOut   (msuOut),
		.multOut  (multOut)
	);

	addShiftUnit uAddShift (
		.addReq  (addReq),
		.subReq  (subReq),
		.shrReq  (shrReq),
		.lAddReq (lAddReq),
		.lSubReq (lSubReq),
		.lShrReq (lShrReq),
		.addOut  (addOut),
		.subOut  (subOut),
		.shrOut  (shrOut),
		.lAddOut (lAddOut),
		.lSubOut (lSubOut),
		.lShrOut (lShrOut)
	);

	////////////////////////////////////////
	// Multi-cycle operators and memory
	////////////////////////////////////////

	longShiftLeft uLongShl (
		.clk      (clk),
		.rst      (rst),
		.shlReady (shlReady),
		.shlReq   (shlReq),
		.shlDone  (shlDone),
		.shlOut   (shlOut)
	);

	normalizer uNorm (
		.clk       (clk),
		.rst       (rst),
		.normReady (normReady),
		.normIn    (normIn),
		.normDone  (normDone),
		.normOut   (normOut)
	);

	scratchMem uScratch (
		.clk        (clk),
		.memSel     (memSel),
		.enginePort (enginePort),
		.testPort   (testPort),
		.memRdata   (memRdata)
	);

endmodule

`default_nettype wire

//--- tb/basicOpPipeTb.sv
`timescale 1ns/1ps
`default_nettype none

module basicOpPipeTb;
	import g729Pkg::*;

	localparam logic [31:0] Seed = 32'hb8c8_394b;
	localparam int CombTests = 400;
	localparam int ShiftTests = 150;
	localparam int NormTests = 150;
	localparam int MemWrites = 150;
	localparam int HangCycles = 40;
	// About 9k cycles worst case for all tests, doubled for margin
	localparam int TimeoutCycles = 20000;

	logic clk;
	logic rst;
	pairReq16 multReq;
	macReq macReqIn;
	macReq msuReqIn;
	pairReq16 addReq;
	pairReq16 subReq;
	pairReq16 shrReq;
	pairReq32 lAddReq;
	pairReq32 lSubReq;
	longShiftReq lShrReq;
	logic shlReady;
	longShiftReq shlReq;
	logic normReady;
	word16 normIn;
	logic memSel;
	memPort enginePort;
	memPort testPort;

	wire longResult lMultOut;
	wire longResult macOut;
	wire longResult msuOut;
	wire word16 multOut;
	wire word16 addOut;
	wire word16 subOut;
	wire word16 shrOut;
	wire word32 lAddOut;
	wire word32 lSubOut;
	wire word32 lShrOut;
	wire shlDone;
	wire word32 shlOut;
	wire normDone;
	wire word16 normOut;
	wire word32 memRdata;

	logic [31:0] rngState;
	int cycleCount = 0;
	word32 memModel [MemDepth];

	basicOpPipe dut0 (.*);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
			abortRun();
		end
	end

	////////////////////////////////////////
	// Error handling and compares
	////////////////////////////////////////

	task automatic abortRun();
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkLong(input string what, input longResult expected,
			input longResult actual);
		if (actual !== expected)
		begin
			$display("FAIL %0t: %s expected ovf %b value %h got ovf %b value %h", $time,
				what, expected.overflow, expected.value, actual.overflow, actual.value);
			abortRun();
		end
	endtask

	task automatic checkWord32(input string what, input word32 expected, input word32 actual);
		if (actual !== expected)
		begin
			$display("FAIL %0t: %s expected %h got %h", $time, what, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkWord16(input string what, input word16 expected, input word16 actual);
		if (actual !== expected)
		begin
			$display("FAIL %0t: %s expected %h got %h", $time, what, expected, actual);
			abortRun();
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// xorshift32
	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// Roughly one operand in four sits on a word limit
	function automatic word16 rand16();
		logic [31:0] r;
		r = nextRand();
		if (r[31:30] == 2'b00)
			return r[29] ? MaxWord16 : MinWord16;
		return word16'(r[15:0]);
	endfunction

	function automatic word32 rand32();
		logic [31:0] r;
		r = nextRand();
		if (r[31:30] == 2'b00)
			return r[29] ? MaxWord32 : MinWord32;
		return word32'(nextRand());
	endfunction

	// Mostly -12..35, sometimes any 16-bit count
	function automatic word16 randCount();
		logic [31:0] r;
		r = nextRand();
		if (r[31:28] == 4'd0)
			return word16'(r[15:0]);
		return word16'(int'(r[7:0] % 8'd48) - 12);
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic longResult satLong(input longint x);
		if (x > longint'(MaxWord32))
			return '{overflow: 1'b1, value: MaxWord32};
		if (x < longint'(MinWord32))
			return '{overflow: 1'b1, value: MinWord32};
		return '{overflow: 1'b0, value: word32'(x)};
	endfunction

	function automatic word16 clampWord16(input longint x);
		if (x > longint'(MaxWord16))
			return MaxWord16;
		if (x < longint'(MinWord16))
			return MinWord16;
		return word16'(x);
	endfunction

	function automatic longResult modelLMult(input word16 a, input word16 b);
		longint p;
		if (a == MinWord16 && b == MinWord16)
			return '{overflow: 1'b1, value: MaxWord32};
		p = longint'(a) * longint'(b) * 2;
		return '{overflow: 1'b0, value: word32'(p)};
	endfunction

	function automatic word16 modelMult(input word16 a, input word16 b);
		if (a == MinWord16 && b == MinWord16)
			return MaxWord16;
		return word16'((longint'(a) * longint'(b)) >>> 15);
	endfunction

	// L_mac when subtract is low, L_msu when high
	function automatic longResult modelMacMsu(input macReq q, input logic subtract);
		longResult p;
		longResult s;
		p = modelLMult(q.a, q.b);
		if (subtract)
			s = satLong(longint'(q.c) - longint'(p.value));
		else
			s = satLong(longint'(q.c) + longint'(p.value));
		s.overflow = s.overflow | p.overflow;
		return s;
	endfunction

	function automatic word16 modelShr(input word16 v, input word16 cnt);
		int n;
		int m;
		n = cnt;
		if (n >= 15)
			return (v < 0) ? -16'sd1 : 16'sd0;
		if (n >= 0)
			return v >>> n;
		// Nonzero values are out of range after 16 places anyway
		m = (-n > 16) ? 16 : -n;
		return clampWord16(longint'(v) * (longint'(1) <<< m));
	endfunction

	function automatic word32 modelLShr(input word32 v, input word16 cnt);
		int n;
		int m;
		longResult sat;
		n = cnt;
		if (n >= 31)
			return (v < 0) ? -32'sd1 : 32'sd0;
		if (n >= 0)
			return v >>> n;
		m = (-n > 32) ? 32 : -n;
		sat = satLong(longint'(v) * (longint'(1) <<< m));
		return sat.value;
	endfunction

	function automatic word32 modelShl(input word32 v, input word16 cnt);
		int n;
		int i;
		n = cnt;
		if (n <= -31)
			return (v < 0) ? -32'sd1 : 32'sd0;
		if (n < 0)
			return v >>> (-n);
		for (i = 0; i < n && i < 40; i++)
		begin
			if (v == 0)
				break;
			// Next doubling would flip the sign
			if (v[31] != v[30])
				return v[31] ? MinWord32 : MaxWord32;
			v = v <<< 1;
		end
		return v;
	endfunction

	function automatic word16 modelNorm(input word16 x);
		int n;
		if (x == 0)
			return 16'sd0;
		if (x == -1)
			return 16'sd15;
		n = 0;
		while (x[15] == x[14])
		begin
			x = x <<< 1;
			n++;
		end
		return word16'(n);
	endfunction

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic checkIdleAfterReset();
		repeat (10)
		begin
			@(negedge clk);
			if (shlDone !== 1'b0 || normDone !== 1'b0)
			begin
				$display("A done pulse appeared after reset without any ready strobe");
				abortRun();
			end
		end
	endtask

	task automatic runCombTest(input int idx);
		longResult sat;
		@(negedge clk);
		multReq = '{a: rand16(), b: rand16()};
		macReqIn = '{a: rand16(), b: rand16(), c: rand32()};
		msuReqIn = '{a: rand16(), b: rand16(), c: rand32()};
		addReq = '{a: rand16(), b: rand16()};
		subReq = '{a: rand16(), b: rand16()};
		shrReq = '{a: rand16(), b: randCount()};
		lAddReq = '{a: rand32(), b: rand32()};
		lSubReq = '{a: rand32(), b: rand32()};
		lShrReq = '{var1: rand32(), numShift: randCount()};
		// The single overflowing product
		if (idx == 0)
		begin
			multReq = '{a: MinWord16, b: MinWord16};
			macReqIn.a = MinWord16;
			macReqIn.b = MinWord16;
			msuReqIn.a = MinWord16;
			msuReqIn.b = MinWord16;
		end
		@(posedge clk);
		checkLong("lMultOut", modelLMult(multReq.a, multReq.b), lMultOut);
		checkWord16("multOut", modelMult(multReq.a, multReq.b), multOut);
		checkLong("macOut", modelMacMsu(macReqIn, 1'b0), macOut);
		checkLong("msuOut", modelMacMsu(msuReqIn, 1'b1), msuOut);
		checkWord16("addOut", clampWord16(longint'(addReq.a) + longint'(addReq.b)), addOut);
		checkWord16("subOut", clampWord16(longint'(subReq.a) - longint'(subReq.b)), subOut);
		checkWord16("shrOut", modelShr(shrReq.a, shrReq.b), shrOut);
		sat = satLong(longint'(lAddReq.a) + longint'(lAddReq.b));
		checkWord32("lAddOut", sat.value, lAddOut);
		sat = satLong(longint'(lSubReq.a) - longint'(lSubReq.b));
		checkWord32("lSubOut", sat.value, lSubOut);
		checkWord32("lShrOut", modelLShr(lShrReq.var1, lShrReq.numShift), lShrOut);
	endtask

	task automatic runShiftTest();
		longShiftReq req;
		word32 expected;
		int waited;
		req.var1 = rand32() >>> (nextRand() % 32);
		req.numShift = randCount();
		expected = modelShl(req.var1, req.numShift);
		@(negedge clk);
		shlReq = req;
		shlReady = 1'b1;
		@(negedge clk);
		shlReady = 1'b0;
		waited = 0;
		while (!shlDone)
		begin
			if (waited >= HangCycles)
			begin
				$display("Long shift unit hung with no shlDone after %0d cycles", HangCycles);
				abortRun();
			end
			// Strobe with other operands while busy
			if (waited == 1)
			begin
				shlReq = '{var1: rand32(), numShift: randCount()};
				shlReady = 1'b1;
			end
			@(negedge clk);
			shlReady = 1'b0;
			waited++;
		end
		checkWord32("shlOut", expected, shlOut);
		@(negedge clk);
		checkWord32("shlOut held", expected, shlOut);
	endtask

	task automatic runNormTest(input int idx);
		word16 value;
		word16 expected;
		int waited;
		case (idx)
			0: value = 16'sd0;
			1: value = -16'sd1;
			2: value = MinWord16;
			3: value = MaxWord16;
			default: value = rand16() >>> (nextRand() % 16);
		endcase
		expected = modelNorm(value);
		@(negedge clk);
		normIn = value;
		normReady = 1'b1;
		@(negedge clk);
		normReady = 1'b0;
		waited = 0;
		while (!normDone)
		begin
			if (waited >= HangCycles)
			begin
				$display("Normalizer hung with no normDone after %0d cycles", HangCycles);
				abortRun();
			end
			@(negedge clk);
			waited++;
		end
		checkWord16("normOut", expected, normOut);
	endtask

	task automatic runMemTest();
		memAddr addr;
		word32 data;
		memAddr readList[$];
		int i;
		// Fill through the test port, engine writes must be dropped
		for (i = 0; i < MemWrites; i++)
		begin
			@(negedge clk);
			memSel = 1'b1;
			addr = memAddr'(nextRand());
			data = word32'(nextRand());
			testPort = '{waddr: addr, wdata: data, we: 1'b1, raddr: '0};
			memModel[addr] = data;
			readList.push_back(addr);
			enginePort = '{waddr: readList[nextRand() % readList.size()],
				wdata: word32'(nextRand()), we: 1'b1, raddr: '0};
		end
		// Read back through the engine port, test writes must be dropped
		@(negedge clk);
		memSel = 1'b0;
		for (i = 0; i < readList.size(); i++)
		begin
			enginePort = '{waddr: '0, wdata: '0, we: 1'b0, raddr: readList[i]};
			testPort = '{waddr: readList[nextRand() % readList.size()],
				wdata: word32'(nextRand()), we: 1'b1, raddr: '0};
			@(negedge clk);
			checkWord32("memRdata", memModel[readList[i]], memRdata);
		end
		testPort.we = 1'b0;
	endtask

	initial
	begin
		int i;
		clk = 1'b0;
		rst = 1'b1;
		multReq = '0;
		macReqIn = '0;
		msuReqIn = '0;
		addReq = '0;
		subReq = '0;
		shrReq = '0;
		lAddReq = '0;
		lSubReq = '0;
		lShrReq = '0;
		shlReady = 1'b0;
		shlReq = '0;
		normReady = 1'b0;
		normIn = '0;
		memSel = 1'b0;
		enginePort = '0;
		testPort = '0;
		rngState = Seed;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		checkIdleAfterReset();
		for (i = 0; i < CombTests; i++)
			runCombTest(i);
		for (i = 0; i < ShiftTests; i++)
			runShiftTest();
		for (i = 0; i < NormTests; i++)
			runNormTest(i);
		runMemTest();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
hw/g729Pkg.sv
hw/mulAccUnit.sv
hw/addShiftUnit.sv
hw/longShiftLeft.sv
hw/normalizer.sv
hw/scratchMem.sv
hw/basicOpPipe.sv
tb/basicOpPipeTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module basicOpPipeTb \
	-f all.f -o basicOpPipeSim \
	&& ./obj_dir/basicOpPipeSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
